//--- rtl/buf_regs.sv
// control and status registers

`default_nettype none

`include "pkt_buf_consts.svh"

module buf_regs (
  input  wire logic                   i_clk,
  input  wire logic                   i_rst,
  // register port.
  input  wire logic                   i_reg_wr,
  input  wire logic                   i_reg_rd,
  input  wire pkt_buf_pkg::reg_addr_t i_reg_addr,
  input  wire pkt_buf_pkg::reg_data_t i_reg_wdata,
  output pkt_buf_pkg::reg_data_t      o_reg_rdata,
  output logic                        o_reg_rvalid,
  // egress events from the fifo.
  input  wire logic                   i_pop,
  input  wire logic                   i_eop,
  input  wire logic                   i_err,
  input  wire pkt_buf_pkg::level_t    i_level,
  // control out.
  output logic                        o_pause
);

  import pkt_buf_pkg::*;

  cnt_t pkts;        // popped beats with eop.
  cnt_t errs;        // popped beats with eop and err.
  reg_data_t rd_mux; // read data before the register.

  ////////////////////////////////////////
  // control register
  ////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_pause <= 1'b0;
    end else if (i_reg_wr && i_reg_addr == `PB_REG_CTRL) begin
      o_pause <= i_reg_wdata[0];  // other addresses read only.
    end
  end

  ////////////////////////////////////////
  // egress counters
  ////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pkts <= '0;
      errs <= '0;
    end else if (i_pop && i_eop) begin
      pkts <= pkts + 1'b1;  // wraps.
      if (i_err) begin
        errs <= errs + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // read path
  ////////////////////////////////////////

  always_comb begin
    case (i_reg_addr)
      `PB_REG_CTRL: rd_mux = reg_data_t'(o_pause);
      `PB_REG_LEVEL: rd_mux = reg_data_t'(i_level);  // live count.
      `PB_REG_PKTS: rd_mux = pkts;
      `PB_REG_ERRS: rd_mux = errs;
      default: rd_mux = '0;
    endcase
  end

  // data one cycle after the strobe.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_reg_rvalid <= 1'b0;
    end else begin
      o_reg_rvalid <= i_reg_rd;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reg_rd) begin
      o_reg_rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

//--- rtl/credit_return.sv
// ingress credit engine

`default_nettype none

`include "pkt_buf_consts.svh"

module credit_return (
  input  wire logic i_clk,
  input  wire logic i_rst,
  input  wire logic i_pop,     // beat left at egress.
  output logic      o_credit   // one credit per high cycle.
);

  import pkt_buf_pkg::*;

  credit_state_t state;
  ptr_t gnt_cnt;   // initial credits handed out so far.
  level_t owed;    // pops not yet returned as credit.

  ////////////////////////////////////////
  // grant, then one credit per pop
  ////////////////////////////////////////

  // a beat can already leave while the grant is running. its credit
  // is held in owed and paid back once the grant is done.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= GRANT;
      gnt_cnt <= '0;
      owed <= '0;
      o_credit <= 1'b0;
    end else begin
      case (state)
        GRANT: begin
          o_credit <= 1'b1;  // one per slot, back to back.
          gnt_cnt <= gnt_cnt + 1'b1;
          if (i_pop) begin
            owed <= owed + 1'b1;
          end
          if (gnt_cnt == ptr_t'(`PB_DEPTH - 1)) begin
            state <= RUN;  // whole depth granted.
          end
        end
        RUN: begin
          o_credit <= i_pop | (owed != '0);
          // a fresh pop takes the slot, backlog waits.
          if (!i_pop && owed != '0) begin
            owed <= owed - 1'b1;
          end
        end
        default: begin
          state <= GRANT;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/pkt_buf_consts.svh
// packet beat buffer constants

`ifndef PKT_BUF_CONSTS_SVH
`define PKT_BUF_CONSTS_SVH

////////////////////////////////////////
// beat field widths
////////////////////////////////////////

`define PB_DAT_BITS 32   // data bus, four bytes.
`define PB_CTL_BITS 8    // sideband control byte.
`define PB_MOD_BITS 2    // valid bytes in last beat, 0 = all four.

////////////////////////////////////////
// storage
////////////////////////////////////////

`define PB_DEPTH 16      // slots, power of two only.
`define PB_DEPTH_BITS 4  // pointer width, log2 of depth.

////////////////////////////////////////
// register map
////////////////////////////////////////

`define PB_REG_CTRL 2'd0   // bit 0 pause.
`define PB_REG_LEVEL 2'd1  // fill count, read only.
`define PB_REG_PKTS 2'd2   // packets sent, read only.
`define PB_REG_ERRS 2'd3   // errored packets sent, read only.

`endif

//--- rtl/pkt_buf_pkg.sv
// packet beat buffer types

`default_nettype none

`include "pkt_buf_consts.svh"

package pkt_buf_pkg;

  ////////////////////////////////////////
  // beat payload
  ////////////////////////////////////////

  typedef logic [`PB_DAT_BITS-1:0] dat_t;  // beat data.
  typedef logic [`PB_CTL_BITS-1:0] ctl_t;  // control byte.
  typedef logic [`PB_MOD_BITS-1:0] mod_t;  // byte modulus.

  ////////////////////////////////////////
  // storage bookkeeping
  ////////////////////////////////////////

  typedef logic [`PB_DEPTH_BITS-1:0] ptr_t;  // slot pointer.
  typedef logic [`PB_DEPTH_BITS:0] level_t;  // 0 to depth inclusive.

  ////////////////////////////////////////
  // register port
  ////////////////////////////////////////

  typedef logic [1:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;
  typedef logic [31:0] cnt_t;  // wrapping packet counters.

  // credit engine, initial grant then steady return.
  typedef enum logic {
    GRANT,
    RUN
  } credit_state_t;

endpackage

`default_nettype wire

//--- rtl/pkt_buf_top.sv
// packet beat buffer top level

`default_nettype none

`include "pkt_buf_consts.svh"

module pkt_buf_top (
  input  wire logic                   i_clk,
  input  wire logic                   i_rst,
  // credit based ingress.
  input  wire logic                   i_in_val,
  input  wire pkt_buf_pkg::dat_t      i_in_dat,
  input  wire pkt_buf_pkg::ctl_t      i_in_ctl,
  input  wire pkt_buf_pkg::mod_t      i_in_mod,
  input  wire logic                   i_in_sop,
  input  wire logic                   i_in_eop,
  input  wire logic                   i_in_err,
  output logic                        o_in_credit,
  // ready/valid egress.
  output logic                        o_out_val,
  output pkt_buf_pkg::dat_t           o_out_dat,
  output pkt_buf_pkg::ctl_t           o_out_ctl,
  output pkt_buf_pkg::mod_t           o_out_mod,
  output logic                        o_out_sop,
  output logic                        o_out_eop,
  output logic                        o_out_err,
  input  wire logic                   i_out_rdy,
  // register port.
  input  wire logic                   i_reg_wr,
  input  wire logic                   i_reg_rd,
  input  wire pkt_buf_pkg::reg_addr_t i_reg_addr,
  input  wire pkt_buf_pkg::reg_data_t i_reg_wdata,
  output pkt_buf_pkg::reg_data_t      o_reg_rdata,
  output logic                        o_reg_rvalid
);

  import pkt_buf_pkg::*;

  logic pause;    // regs to fifo.
  logic pop;      // beat accepted at egress.
  level_t level;  // fill count.

  ////////////////////////////////////////
  // beat storage
  ////////////////////////////////////////

  stream_fifo u_fifo (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_wr    (i_in_val),  // every offered beat is written.
    .i_dat   (i_in_dat),
    .i_ctl   (i_in_ctl),
    .i_mod   (i_in_mod),
    .i_sop   (i_in_sop),
    .i_eop   (i_in_eop),
    .i_err   (i_in_err),
    .i_pause (pause),
    .i_rdy   (i_out_rdy),
    .o_val   (o_out_val),
    .o_dat   (o_out_dat),
    .o_ctl   (o_out_ctl),
    .o_mod   (o_out_mod),
    .o_sop   (o_out_sop),
    .o_eop   (o_out_eop),
    .o_err   (o_out_err),
    .o_pop   (pop),
    .o_level (level)
  );

  ////////////////////////////////////////
  // credits and registers
  ////////////////////////////////////////

  credit_return u_credit (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_pop    (pop),
    .o_credit (o_in_credit)
  );

  buf_regs u_regs (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_reg_wr     (i_reg_wr),
    .i_reg_rd     (i_reg_rd),
    .i_reg_addr   (i_reg_addr),
    .i_reg_wdata  (i_reg_wdata),
    .o_reg_rdata  (o_reg_rdata),
    .o_reg_rvalid (o_reg_rvalid),
    .i_pop        (pop),
    .i_eop        (o_out_eop),  // flags of the beat being popped.
    .i_err        (o_out_err),
    .i_level      (level),
    .o_pause      (pause)
  );

endmodule

`default_nettype wire

//--- rtl/stream_fifo.sv
// stream beat fifo
// register array, one cycle fall-through

`default_nettype none

`include "pkt_buf_consts.svh"

module stream_fifo (
  input  wire logic                  i_clk,
  input  wire logic                  i_rst,
  // write side, no ready, credit protected.
  input  wire logic                  i_wr,
  input  wire pkt_buf_pkg::dat_t     i_dat,
  input  wire pkt_buf_pkg::ctl_t     i_ctl,
  input  wire pkt_buf_pkg::mod_t     i_mod,
  input  wire logic                  i_sop,
  input  wire logic                  i_eop,
  input  wire logic                  i_err,
  // egress steering.
  input  wire logic                  i_pause,
  input  wire logic                  i_rdy,
  // read side.
  output logic                       o_val,
  output pkt_buf_pkg::dat_t          o_dat,
  output pkt_buf_pkg::ctl_t          o_ctl,
  output pkt_buf_pkg::mod_t          o_mod,
  output logic                       o_sop,
  output logic                       o_eop,
  output logic                       o_err,
  // status.
  output logic                       o_pop,
  output pkt_buf_pkg::level_t        o_level
);

  import pkt_buf_pkg::*;

  // err, eop, sop, mod, ctl, dat packed msb first.
  localparam int BEAT_BITS = `PB_DAT_BITS + `PB_CTL_BITS + `PB_MOD_BITS + 3;

  logic [BEAT_BITS-1:0] mem [`PB_DEPTH];  // beat slots.
  logic [BEAT_BITS-1:0] rd_beat;          // head of queue.

  ptr_t rd_ptr;
  ptr_t wr_ptr;
  ptr_t rd_nxt;
  ptr_t wr_nxt;
  logic full;
  logic emp;
  logic wr_en;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  // guard against a misbehaving sender.
  always_comb begin
    wr_en = i_wr & ~full;
    wr_nxt = wr_ptr + 1'b1;  // wraps at depth.
    rd_nxt = rd_ptr + 1'b1;
  end

  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= {i_err, i_eop, i_sop, i_mod, i_ctl, i_dat};
    end
  end

  // head beat straight from the array, no output register.
  always_comb begin
    rd_beat = mem[rd_ptr];
    {o_err, o_eop, o_sop, o_mod, o_ctl, o_dat} = rd_beat;
  end

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  always_comb begin
    o_val = ~emp & ~i_pause;  // pause hides the head beat.
    o_pop = o_val & i_rdy;    // beat leaves this cycle.
  end

  ////////////////////////////////////////
  // pointers, flags, level
  ////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      emp <= 1'b1;
      full <= 1'b0;
      o_level <= '0;
    end else begin
      if (wr_en && o_pop) begin
        // both ends move, flags and level hold.
        wr_ptr <= wr_nxt;
        rd_ptr <= rd_nxt;
      end else if (wr_en) begin
        emp <= 1'b0;
        wr_ptr <= wr_nxt;
        o_level <= o_level + 1'b1;
        if (wr_nxt == rd_ptr) begin
          full <= 1'b1;  // write caught up with read.
        end
      end else if (o_pop) begin
        full <= 1'b0;
        rd_ptr <= rd_nxt;
        o_level <= o_level - 1'b1;
        if (rd_nxt == wr_ptr) begin
          emp <= 1'b1;  // last beat gone.
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the packet buffer testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pkt_buf_tb -f sim.f \
  || { echo "build failed"; exit 1; }
./obj_dir/Vpkt_buf_tb > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "all tests passed" sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation PASSED"
exit 0

//--- sim.f
+incdir+rtl
rtl/pkt_buf_pkg.sv
rtl/stream_fifo.sv
rtl/credit_return.sv
rtl/buf_regs.sv
rtl/pkt_buf_top.sv
verif/pkt_buf_tb.sv

//--- verif/pkt_buf_tb.sv
// packet beat buffer testbench

`default_nettype none

`include "pkt_buf_consts.svh"

module pkt_buf_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import pkt_buf_pkg::*;

  localparam int BEAT_W = `PB_DAT_BITS + `PB_CTL_BITS + `PB_MOD_BITS + 3;
  localparam int RAND_BEATS = 320;             // random traffic phase.
  localparam int MAX_CYCLES = 400 * 4 + 200;   // run limit.

  logic i_clk;
  logic i_rst;
  logic i_in_val;
  dat_t i_in_dat;
  ctl_t i_in_ctl;
  mod_t i_in_mod;
  logic i_in_sop;
  logic i_in_eop;
  logic i_in_err;
  logic o_in_credit;
  logic o_out_val;
  dat_t o_out_dat;
  ctl_t o_out_ctl;
  mod_t o_out_mod;
  logic o_out_sop;
  logic o_out_eop;
  logic o_out_err;
  logic i_out_rdy;
  logic i_reg_wr;
  logic i_reg_rd;
  reg_addr_t i_reg_addr;
  reg_data_t i_reg_wdata;
  reg_data_t o_reg_rdata;
  logic o_reg_rvalid;

  logic [31:0] lfsr = 32'h6ae2;    // stimulus source.
  logic [BEAT_W-1:0] sb_q [$];     // beats sent and not yet popped.
  int credits = 0;                 // sender's credit count.
  int sent = 0;
  int send_limit = 0;
  int cycle_cnt = 0;
  cnt_t exp_pkts = '0;
  cnt_t exp_errs = '0;
  reg_data_t rd_data = '0;
  bit rvalid_seen = 1'b0;
  bit last_credit = 1'b0;
  bit grant_done = 1'b0;
  bit pause_set = 1'b0;            // shadow of the CTRL pause bit.
  bit send_on = 1'b0;
  bit rdy_rand = 1'b0;
  bit rdy_fixed = 1'b0;
  bit next_sop = 1'b1;             // first beat opens a packet.

  pkt_buf_top UUT (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_in_val     (i_in_val),
    .i_in_dat     (i_in_dat),
    .i_in_ctl     (i_in_ctl),
    .i_in_mod     (i_in_mod),
    .i_in_sop     (i_in_sop),
    .i_in_eop     (i_in_eop),
    .i_in_err     (i_in_err),
    .o_in_credit  (o_in_credit),
    .o_out_val    (o_out_val),
    .o_out_dat    (o_out_dat),
    .o_out_ctl    (o_out_ctl),
    .o_out_mod    (o_out_mod),
    .o_out_sop    (o_out_sop),
    .o_out_eop    (o_out_eop),
    .o_out_err    (o_out_err),
    .i_out_rdy    (i_out_rdy),
    .i_reg_wr     (i_reg_wr),
    .i_reg_rd     (i_reg_rd),
    .i_reg_addr   (i_reg_addr),
    .i_reg_wdata  (i_reg_wdata),
    .o_reg_rdata  (o_reg_rdata),
    .o_reg_rvalid (o_reg_rvalid)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;  // 100 ns period.
  end

  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("run did not finish within %0d cycles, timeout", MAX_CYCLES);
      stop_with_failure();
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic stop_with_failure();
    $display("tests failed");
    $fatal(1, "simulation stopped on a failed check");
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    stop_with_failure();
  endtask

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic send_beat();
    dat_t dat;
    ctl_t ctl;
    mod_t md;
    logic eop;
    logic err;
    dat = dat_t'(take_bits(`PB_DAT_BITS));
    ctl = ctl_t'(take_bits(`PB_CTL_BITS));
    md = mod_t'(take_bits(`PB_MOD_BITS));
    eop = (take_bits(2) == 32'd3);  // about one beat in four ends a packet.
    err = (take_bits(1) != 32'd0);
    i_in_val <= 1'b1;
    i_in_dat <= dat;
    i_in_ctl <= ctl;
    i_in_mod <= md;
    i_in_sop <= next_sop;
    i_in_eop <= eop;
    i_in_err <= err;
    sb_q.push_back({err, eop, next_sop, md, ctl, dat});
    next_sop = eop;
    credits--;  // one credit per beat.
    sent++;
  endtask

  task automatic check_pop();
    logic [BEAT_W-1:0] got;
    logic [BEAT_W-1:0] want;
    got = {o_out_err, o_out_eop, o_out_sop, o_out_mod, o_out_ctl, o_out_dat};
    assert (sb_q.size() > 0) else report_error("beat popped with empty scoreboard");
    want = sb_q.pop_front();
    assert (got == want)
      else report_error($sformatf("egress beat %h, expected %h", got, want));
    if (want[BEAT_W-2]) begin
      exp_pkts++;  // eop seen.
      if (want[BEAT_W-1]) begin
        exp_errs++;
      end
    end
  endtask

  // one clock that reads pre-edge outputs and then drives the next cycle.
  task automatic tick();
    @(posedge i_clk);
    last_credit = o_in_credit;
    if (o_in_credit) begin
      credits++;
    end
    if (o_out_val && i_out_rdy) begin
      check_pop();
    end
    if (o_reg_rvalid) begin
      rd_data = o_reg_rdata;
      rvalid_seen = 1'b1;
    end
    i_in_val <= 1'b0;
    i_reg_wr <= 1'b0;
    i_reg_rd <= 1'b0;
    if (send_on && credits > 0 && sent < send_limit && take_bits(1) != 32'd0) begin
      send_beat();
    end
    if (rdy_rand) begin
      i_out_rdy <= (take_bits(2) != 32'd0);  // ready three cycles in four.
    end else begin
      i_out_rdy <= rdy_fixed;
    end
    assert (credits >= 0 && credits <= `PB_DEPTH)
      else report_error($sformatf("sender credit count %0d out of range", credits));
    assert (credits + sb_q.size() <= `PB_DEPTH)
      else report_error($sformatf("credits %0d plus stored %0d exceed depth",
                                  credits, sb_q.size()));
  endtask

  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    i_reg_wr <= 1'b1;
    i_reg_addr <= addr;
    i_reg_wdata <= data;
    tick();
  endtask

  task automatic check_reg(input reg_addr_t addr, input reg_data_t want);
    rvalid_seen = 1'b0;
    i_reg_rd <= 1'b1;
    i_reg_addr <= addr;
    tick();
    while (!rvalid_seen) begin
      tick();
    end
    assert (rd_data == want)
      else report_error($sformatf("register %0d read %0d, expected %0d", addr, rd_data, want));
  endtask

  // stop sending, empty the buffer, expect every credit back.
  task automatic drain();
    send_on = 1'b0;
    rdy_rand = 1'b0;
    rdy_fixed = 1'b1;
    while (sb_q.size() != 0) begin
      tick();
    end
    repeat (2) tick();
    assert (credits == `PB_DEPTH)
      else report_error($sformatf("sender holds %0d credits after drain", credits));
  endtask

  ////////////////////////////////////////
  // protocol checks
  ////////////////////////////////////////

  assert property (@(posedge i_clk) disable iff (i_rst)
    o_out_val && !i_out_rdy |=> o_out_val &&
      $stable({o_out_err, o_out_eop, o_out_sop, o_out_mod, o_out_ctl, o_out_dat}))
    else report_error("egress beat changed or dropped before it was accepted");

  assert property (@(posedge i_clk) disable iff (i_rst)
    i_in_val && !o_out_val && !pause_set |=> o_out_val)
    else report_error("beat written to empty buffer not valid one cycle later");

  assert property (@(posedge i_clk) disable iff (i_rst)
    grant_done && o_out_val && i_out_rdy |=> o_in_credit)
    else report_error("no credit returned in the cycle after a pop");

  assert property (@(posedge i_clk) disable iff (i_rst) i_reg_rd |=> o_reg_rvalid)
    else report_error("register read data not valid one cycle after the strobe");

  assert property (@(posedge i_clk) disable iff (i_rst) !i_reg_rd |=> !o_reg_rvalid)
    else report_error("register read valid without a read strobe");

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    i_rst = 1'b1;
    i_in_val = 1'b0;
    i_in_dat = '0;
    i_in_ctl = '0;
    i_in_mod = '0;
    i_in_sop = 1'b0;
    i_in_eop = 1'b0;
    i_in_err = 1'b0;
    i_out_rdy = 1'b0;
    i_reg_wr = 1'b0;
    i_reg_rd = 1'b0;
    i_reg_addr = '0;
    i_reg_wdata = '0;
    repeat (4) @(posedge i_clk);
    i_rst <= 1'b0;

    // initial grant gives one credit per slot back to back.
    for (int k = 0; k < 24; k++) begin
      tick();
      assert (last_credit == (k >= 1 && k <= `PB_DEPTH))
        else report_error($sformatf("credit %0d in grant cycle %0d", last_credit, k));
      assert (!o_out_val && !o_reg_rvalid)
        else report_error("egress or read valid high with no traffic");
    end
    grant_done = 1'b1;
    check_reg(`PB_REG_CTRL, '0);
    check_reg(`PB_REG_LEVEL, '0);
    check_reg(`PB_REG_PKTS, '0);
    check_reg(`PB_REG_ERRS, '0);

    // random valid and ready gaps.
    send_limit = RAND_BEATS;
    send_on = 1'b1;
    rdy_rand = 1'b1;
    while (sent < send_limit) begin
      tick();
    end
    drain();

    // pause, fill all slots, then release.
    pause_set = 1'b1;
    reg_write(`PB_REG_CTRL, 32'd1);
    tick();
    send_limit = sent + `PB_DEPTH;
    send_on = 1'b1;
    while (sent < send_limit) begin
      tick();
      assert (!o_out_val) else report_error("egress valid while paused");
    end
    send_on = 1'b0;
    repeat (2) begin
      tick();
      assert (!o_out_val) else report_error("egress valid while paused");
    end
    assert (credits == 0)
      else report_error($sformatf("sender holds %0d credits with buffer full", credits));
    check_reg(`PB_REG_LEVEL, reg_data_t'(`PB_DEPTH));
    reg_write(`PB_REG_CTRL, 32'd0);
    pause_set = 1'b0;
    drain();
    check_reg(`PB_REG_LEVEL, '0);

    // egress counters against own tallies.
    check_reg(`PB_REG_PKTS, exp_pkts);
    check_reg(`PB_REG_ERRS, exp_errs);
    check_reg(`PB_REG_CTRL, '0);

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire
